// File: hw/uop_types.sv
package uop_types;

    // data and address words, also pc and branch targets.
    typedef logic [31:0] word_t;

    // performance counters wrap at 32 bits.
    typedef logic [31:0] perf_cnt_t;

    // bit 3 set marks an unconditional op.
    typedef logic [3:0] br_op_t;

    localparam br_op_t BR_BEQ   = 4'd0;
    localparam br_op_t BR_BNE   = 4'd1;
    localparam br_op_t BR_BLT   = 4'd4;
    localparam br_op_t BR_BGE   = 4'd5;
    localparam br_op_t BR_BLTU  = 4'd6;
    localparam br_op_t BR_BGEU  = 4'd7;
    localparam br_op_t BR_JAL   = 4'd8;
    localparam br_op_t BR_JALR  = 4'd9;
    localparam br_op_t BR_AUIPC = 4'd10; // shares the unit, but is never a branch.

    typedef logic [1:0] rs_kind_t;

    localparam rs_kind_t RS_INT  = 2'd0;
    localparam rs_kind_t RS_INTM = 2'd1;
    localparam rs_kind_t RS_BR   = 2'd2;
    localparam rs_kind_t RS_MEM  = 2'd3;
    localparam int       RS_NUM  = 4;

    // counter select of the monitor read port.
    typedef logic [3:0] perf_sel_t;

    localparam perf_sel_t SEL_BR          = 4'd0;
    localparam perf_sel_t SEL_BR_MISS     = 4'd1;
    localparam perf_sel_t SEL_COND        = 4'd2;
    localparam perf_sel_t SEL_COND_MISS   = 4'd3;
    localparam perf_sel_t SEL_UNCOND      = 4'd4;
    localparam perf_sel_t SEL_UNCOND_MISS = 4'd5;
    localparam perf_sel_t SEL_INT_BLK     = 4'd6;
    localparam perf_sel_t SEL_INTM_BLK    = 4'd7;
    localparam perf_sel_t SEL_BR_BLK      = 4'd8;
    localparam perf_sel_t SEL_MEM_BLK     = 4'd9;

endpackage

// File: hw/br_resolve_if.sv
`timescale 1ns/10ps

// one resolved branch per cycle while valid is high.
interface br_resolve_if;
    import uop_types::*;

    logic   valid;
    br_op_t opcode;
    logic   mispredict;
    word_t  target;     // correct next pc of the branch.

    modport fu (
        output valid,
        output opcode,
        output mispredict,
        output target
    );

    modport mon (
        input valid,
        input opcode,
        input mispredict,
        input target
    );

endinterface

// File: hw/ds_perf_if.sv
`timescale 1ns/10ps

// block cycle counts of the dispatch stage, one per station class.
interface ds_perf_if;
    import uop_types::*;

    perf_cnt_t int_blk;
    perf_cnt_t intm_blk;
    perf_cnt_t br_blk;
    perf_cnt_t mem_blk;

    modport ds (
        output int_blk,
        output intm_blk,
        output br_blk,
        output mem_blk
    );

    modport mon (
        input int_blk,
        input intm_blk,
        input br_blk,
        input mem_blk
    );

endinterface

// File: hw/fu_br.sv
`timescale 1ns/10ps

module fu_br (
    input  logic                clk,
    input  logic                rst,
    input  logic                br_valid_i,
    input  uop_types::br_op_t   br_opcode_i,
    input  uop_types::word_t    br_pc_i,
    input  uop_types::word_t    br_rs1_i,
    input  uop_types::word_t    br_rs2_i,
    input  uop_types::word_t    br_imm_i,
    input  logic                br_pred_taken_i,
    input  uop_types::word_t    br_pred_target_i,
    output logic                redirect_valid_o,
    output uop_types::word_t    redirect_pc_o,
    br_resolve_if.fu            res
);
    import uop_types::*;

    logic   taken;
    logic   is_branch;
    logic   mispredict;
    word_t  jalr_sum;
    word_t  taken_target;
    word_t  next_pc;

    logic   valid_q;
    logic   redirect_q;
    br_op_t opcode_q;
    logic   mispredict_q;
    word_t  next_pc_q;

    assign jalr_sum = br_rs1_i + br_imm_i;

    always_comb begin
        taken        = 1'b0;
        is_branch    = 1'b1;
        taken_target = br_pc_i + br_imm_i;
        case (br_opcode_i)
            BR_BEQ:  taken = (br_rs1_i == br_rs2_i);
            BR_BNE:  taken = (br_rs1_i != br_rs2_i);
            BR_BLT:  taken = ($signed(br_rs1_i) < $signed(br_rs2_i));
            BR_BGE:  taken = ($signed(br_rs1_i) >= $signed(br_rs2_i));
            BR_BLTU: taken = (br_rs1_i < br_rs2_i);
            BR_BGEU: taken = (br_rs1_i >= br_rs2_i);
            BR_JAL:  taken = 1'b1;
            BR_JALR: begin
                taken        = 1'b1;
                taken_target = {jalr_sum[31:1], 1'b0};
            end
            default: is_branch = 1'b0; // auipc and unused codes fall through as not taken.
        endcase
    end

    // a taken branch can still miss when the predicted target is stale.
    always_comb begin
        mispredict = 1'b0;
        if (is_branch) begin
            if (taken != br_pred_taken_i) begin
                mispredict = 1'b1;
            end else if (taken && (taken_target != br_pred_target_i)) begin
                mispredict = 1'b1;
            end
        end
    end

    assign next_pc = taken ? taken_target : br_pc_i + word_t'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            valid_q    <= br_valid_i;
            redirect_q <= br_valid_i && mispredict;
        end
    end

    always_ff @(posedge clk) begin
        opcode_q     <= br_opcode_i;
        mispredict_q <= mispredict;
        next_pc_q    <= next_pc;
    end

    assign redirect_valid_o = redirect_q;
    assign redirect_pc_o    = next_pc_q;

    assign res.valid      = valid_q;
    assign res.opcode     = opcode_q;
    assign res.mispredict = mispredict_q;
    assign res.target     = next_pc_q;

endmodule

// File: hw/ds_stage.sv
`timescale 1ns/10ps

module ds_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            uop_valid_i,
    input  uop_types::rs_kind_t             uop_kind_i,
    input  logic [uop_types::RS_NUM-1:0]    rs_full_i,
    output logic                            uop_ready_o,
    output logic [uop_types::RS_NUM-1:0]    rs_dispatch_o,
    ds_perf_if.ds                           perf
);
    import uop_types::*;

    logic       stall;
    perf_cnt_t  blk_cnt [RS_NUM];

    // ready follows the fullness of the station that the kind selects.
    assign uop_ready_o = !rs_full_i[uop_kind_i];
    assign stall       = uop_valid_i && rs_full_i[uop_kind_i];

    always_comb begin
        rs_dispatch_o = '0;
        if (uop_valid_i && uop_ready_o) begin
            rs_dispatch_o[uop_kind_i] = 1'b1;
        end
    end

    // The source holds a stalled micro-op, so a long stall counts once per cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            blk_cnt <= '{default: '0};
        end else if (stall) begin
            blk_cnt[uop_kind_i] <= blk_cnt[uop_kind_i] + perf_cnt_t'(1);
        end
    end

    assign perf.int_blk  = blk_cnt[RS_INT];
    assign perf.intm_blk = blk_cnt[RS_INTM];
    assign perf.br_blk   = blk_cnt[RS_BR];
    assign perf.mem_blk  = blk_cnt[RS_MEM];

endmodule

// File: hw/perf_monitor.sv
`timescale 1ns/10ps

module perf_monitor (
    input  logic                    clk,
    input  logic                    rst,
    input  uop_types::perf_sel_t    perf_sel_i,
    output uop_types::perf_cnt_t    perf_rdata_o,
    br_resolve_if.mon               res,
    ds_perf_if.mon                  ds
);
    import uop_types::*;

    perf_cnt_t  br_cnt;
    perf_cnt_t  br_miss_cnt;
    perf_cnt_t  cond_cnt;
    perf_cnt_t  cond_miss_cnt;
    perf_cnt_t  uncond_cnt;
    perf_cnt_t  uncond_miss_cnt;
    perf_cnt_t  miss_inc;
    logic       is_auipc;

    assign is_auipc = (res.opcode == BR_AUIPC);
    assign miss_inc = perf_cnt_t'(res.mispredict);

    always_ff @(posedge clk) begin
        if (rst) begin
            br_cnt      <= '0;
            br_miss_cnt <= '0;
        end else if (res.valid && !is_auipc) begin
            br_cnt      <= br_cnt + perf_cnt_t'(1);
            br_miss_cnt <= br_miss_cnt + miss_inc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cond_cnt      <= '0;
            cond_miss_cnt <= '0;
        end else if (res.valid && !res.opcode[3]) begin
            cond_cnt      <= cond_cnt + perf_cnt_t'(1);
            cond_miss_cnt <= cond_miss_cnt + miss_inc;
        end
    end

    // auipc sits in the unconditional half of the opcode space.
    always_ff @(posedge clk) begin
        if (rst) begin
            uncond_cnt      <= '0;
            uncond_miss_cnt <= '0;
        end else if (res.valid && res.opcode[3] && !is_auipc) begin
            uncond_cnt      <= uncond_cnt + perf_cnt_t'(1);
            uncond_miss_cnt <= uncond_miss_cnt + miss_inc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            perf_rdata_o <= '0;
        end else begin
            case (perf_sel_i)
                SEL_BR:          perf_rdata_o <= br_cnt;
                SEL_BR_MISS:     perf_rdata_o <= br_miss_cnt;
                SEL_COND:        perf_rdata_o <= cond_cnt;
                SEL_COND_MISS:   perf_rdata_o <= cond_miss_cnt;
                SEL_UNCOND:      perf_rdata_o <= uncond_cnt;
                SEL_UNCOND_MISS: perf_rdata_o <= uncond_miss_cnt;
                SEL_INT_BLK:     perf_rdata_o <= ds.int_blk;
                SEL_INTM_BLK:    perf_rdata_o <= ds.intm_blk;
                SEL_BR_BLK:      perf_rdata_o <= ds.br_blk;
                SEL_MEM_BLK:     perf_rdata_o <= ds.mem_blk;
                default:         perf_rdata_o <= '0; // unused selects read zero.
            endcase
        end
    end

endmodule

// File: hw/backend_top.sv
`timescale 1ns/10ps

module backend_top (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            br_valid_i,
    input  uop_types::br_op_t               br_opcode_i,
    input  uop_types::word_t                br_pc_i,
    input  uop_types::word_t                br_rs1_i,
    input  uop_types::word_t                br_rs2_i,
    input  uop_types::word_t                br_imm_i,
    input  logic                            br_pred_taken_i,
    input  uop_types::word_t                br_pred_target_i,
    output logic                            redirect_valid_o,
    output uop_types::word_t                redirect_pc_o,

    input  logic                            uop_valid_i,
    input  uop_types::rs_kind_t             uop_kind_i,
    input  logic [uop_types::RS_NUM-1:0]    rs_full_i,
    output logic                            uop_ready_o,
    output logic [uop_types::RS_NUM-1:0]    rs_dispatch_o,

    input  uop_types::perf_sel_t            perf_sel_i,
    output uop_types::perf_cnt_t            perf_rdata_o
);

    br_resolve_if br_res ();
    ds_perf_if    ds_perf ();

    fu_br fu_br_i (
        .clk              (clk),
        .rst              (rst),
        .br_valid_i       (br_valid_i),
        .br_opcode_i      (br_opcode_i),
        .br_pc_i          (br_pc_i),
        .br_rs1_i         (br_rs1_i),
        .br_rs2_i         (br_rs2_i),
        .br_imm_i         (br_imm_i),
        .br_pred_taken_i  (br_pred_taken_i),
        .br_pred_target_i (br_pred_target_i),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .res              (br_res.fu)
    );

    ds_stage ds_stage_i (
        .clk           (clk),
        .rst           (rst),
        .uop_valid_i   (uop_valid_i),
        .uop_kind_i    (uop_kind_i),
        .rs_full_i     (rs_full_i),
        .uop_ready_o   (uop_ready_o),
        .rs_dispatch_o (rs_dispatch_o),
        .perf          (ds_perf.ds)
    );

    // the monitor only observes and drives nothing back into the pipeline.
    perf_monitor perf_monitor_i (
        .clk          (clk),
        .rst          (rst),
        .perf_sel_i   (perf_sel_i),
        .perf_rdata_o (perf_rdata_o),
        .res          (br_res.mon),
        .ds           (ds_perf.mon)
    );

endmodule

// File: tests/top_tb.sv
`timescale 1ns/10ps

module top_tb;
    import uop_types::*;

    // one branch micro-op and the response that the fu_br rules give for it.
    typedef struct {
        br_op_t op;
        word_t  pc;
        word_t  rs1;
        word_t  rs2;
        word_t  imm;
        logic   pred_taken;
        word_t  pred_target;
        logic   exp_mis;
        word_t  exp_pc;
    } br_row_t;

    localparam int DS_CYCLES  = 40;
    localparam int HOLD_LIMIT = 32; // cycles a held micro-op may wait for ready.

    logic                clk;
    logic                rst;
    logic                br_valid_i;
    br_op_t              br_opcode_i;
    word_t               br_pc_i;
    word_t               br_rs1_i;
    word_t               br_rs2_i;
    word_t               br_imm_i;
    logic                br_pred_taken_i;
    word_t               br_pred_target_i;
    logic                redirect_valid_o;
    word_t               redirect_pc_o;
    logic                uop_valid_i;
    rs_kind_t            uop_kind_i;
    logic [RS_NUM-1:0]   rs_full_i;
    logic                uop_ready_o;
    logic [RS_NUM-1:0]   rs_dispatch_o;
    perf_sel_t           perf_sel_i;
    perf_cnt_t           perf_rdata_o;

    br_row_t             br_table[$];
    perf_cnt_t           exp_blk [RS_NUM];
    perf_cnt_t           exp_br;
    perf_cnt_t           exp_br_miss;
    perf_cnt_t           exp_cond;
    perf_cnt_t           exp_cond_miss;
    perf_cnt_t           exp_uncond;
    perf_cnt_t           exp_uncond_miss;

    backend_top UUT (
        .clk              (clk),
        .rst              (rst),
        .br_valid_i       (br_valid_i),
        .br_opcode_i      (br_opcode_i),
        .br_pc_i          (br_pc_i),
        .br_rs1_i         (br_rs1_i),
        .br_rs2_i         (br_rs2_i),
        .br_imm_i         (br_imm_i),
        .br_pred_taken_i  (br_pred_taken_i),
        .br_pred_target_i (br_pred_target_i),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .uop_valid_i      (uop_valid_i),
        .uop_kind_i       (uop_kind_i),
        .rs_full_i        (rs_full_i),
        .uop_ready_o      (uop_ready_o),
        .rs_dispatch_o    (rs_dispatch_o),
        .perf_sel_i       (perf_sel_i),
        .perf_rdata_o     (perf_rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error.");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic add_branch(input br_op_t op, input word_t pc, input word_t rs1,
                              input word_t rs2, input word_t imm, input logic pred_taken,
                              input word_t pred_target, input logic exp_mis,
                              input word_t exp_pc);
        br_row_t row;
        row = '{op, pc, rs1, rs2, imm, pred_taken, pred_target, exp_mis, exp_pc};
        br_table.push_back(row);
    endtask

    task automatic build_table();
        //         op        pc        rs1           rs2           imm
        //         pred_t  pred_target  mispredict  next pc
        add_branch(BR_BEQ,  32'h100, 32'h5,        32'h5,        32'h20,
                   1'b1, 32'h120,  1'b0, 32'h120);
        add_branch(BR_BEQ,  32'h104, 32'h5,        32'h6,        32'h20,
                   1'b1, 32'h124,  1'b1, 32'h108);
        add_branch(BR_BNE,  32'h108, 32'h1,        32'h2,        32'h10,
                   1'b0, 32'h0,    1'b1, 32'h118);
        add_branch(BR_BNE,  32'h10c, 32'h7,        32'h7,        32'h10,
                   1'b0, 32'h0,    1'b0, 32'h110);
        add_branch(BR_BLT,  32'h200, 32'hffff_ffff, 32'h1,       32'h40,
                   1'b1, 32'h240,  1'b0, 32'h240); // -1 is less than 1 when signed.
        add_branch(BR_BLTU, 32'h204, 32'hffff_ffff, 32'h1,       32'h40,
                   1'b1, 32'h244,  1'b1, 32'h208);
        add_branch(BR_BGE,  32'h208, 32'h8000_0000, 32'h0,       32'h8,
                   1'b0, 32'h0,    1'b0, 32'h20c);
        add_branch(BR_BGEU, 32'h20c, 32'h8000_0000, 32'h0,       32'h8,
                   1'b0, 32'h0,    1'b1, 32'h214);
        add_branch(BR_BGE,  32'h210, 32'h3,        32'h3,        32'hffff_fff0,
                   1'b1, 32'h200,  1'b0, 32'h200);
        // taken as predicted, but to a stale target.
        add_branch(BR_BLT,  32'h300, 32'hffff_fffe, 32'hffff_ffff, 32'h20,
                   1'b1, 32'h3f0,  1'b1, 32'h320);
        add_branch(BR_BLTU, 32'h304, 32'h10,       32'h10,       32'h20,
                   1'b0, 32'h0,    1'b0, 32'h308);
        add_branch(BR_BGEU, 32'h308, 32'h1,        32'hffff_ffff, 32'h20,
                   1'b1, 32'h328,  1'b1, 32'h30c);
        add_branch(BR_JAL,  32'h400, 32'h0,        32'h0,        32'h100,
                   1'b1, 32'h500,  1'b0, 32'h500);
        add_branch(BR_JAL,  32'h404, 32'h0,        32'h0,        32'h100,
                   1'b0, 32'h0,    1'b1, 32'h504);
        add_branch(BR_JALR, 32'h408, 32'h1001,     32'h0,        32'h10,
                   1'b1, 32'h1010, 1'b0, 32'h1010);
        add_branch(BR_JALR, 32'h40c, 32'h2000,     32'h0,        32'h7,
                   1'b1, 32'h2007, 1'b1, 32'h2006);
        add_branch(BR_AUIPC, 32'h500, 32'h0,       32'h0,        32'h1000,
                   1'b1, 32'h1500, 1'b0, 32'h504);
        add_branch(BR_AUIPC, 32'h504, 32'h0,       32'h0,        32'h1000,
                   1'b0, 32'h0,    1'b0, 32'h508);
    endtask

    // auipc is no branch, and bit 3 splits the rest into conditional and unconditional.
    task automatic tally_branches();
        foreach (br_table[i]) begin
            if (br_table[i].op != BR_AUIPC) begin
                exp_br      = exp_br + 1;
                exp_br_miss = exp_br_miss + perf_cnt_t'(br_table[i].exp_mis);
            end
            if (!br_table[i].op[3]) begin
                exp_cond      = exp_cond + 1;
                exp_cond_miss = exp_cond_miss + perf_cnt_t'(br_table[i].exp_mis);
            end else if (br_table[i].op != BR_AUIPC) begin
                exp_uncond      = exp_uncond + 1;
                exp_uncond_miss = exp_uncond_miss + perf_cnt_t'(br_table[i].exp_mis);
            end
        end
    endtask

    // each row's result shows up on the falling edge that drives the next row.
    task automatic run_branches();
        br_row_t row;
        for (int i = 0; i <= br_table.size(); i++) begin
            @(negedge clk);
            if (i > 0) begin
                row = br_table[i-1];
                check_word("redirect_valid_o", word_t'(redirect_valid_o), word_t'(row.exp_mis));
                check_word("redirect_pc_o", redirect_pc_o, row.exp_pc);
            end
            if (i < br_table.size()) begin
                row              = br_table[i];
                br_valid_i       = 1'b1;
                br_opcode_i      = row.op;
                br_pc_i          = row.pc;
                br_rs1_i         = row.rs1;
                br_rs2_i         = row.rs2;
                br_imm_i         = row.imm;
                br_pred_taken_i  = row.pred_taken;
                br_pred_target_i = row.pred_target;
            end else begin
                br_valid_i      = 1'b0; // a jump that would mispredict if it were valid.
                br_opcode_i     = BR_JAL;
                br_pred_taken_i = 1'b0;
            end
        end
        @(negedge clk);
        check_word("redirect_valid_o", word_t'(redirect_valid_o), '0);
    endtask

    task automatic run_dispatch();
        logic [31:0]       rnd;
        rs_kind_t          kind;
        logic [RS_NUM-1:0] full;
        logic              exp_ready;
        logic [RS_NUM-1:0] exp_disp;
        logic              accepted;
        int                cycles;
        int                tries;
        cycles = 0;
        while (cycles < DS_CYCLES) begin
            rnd      = $urandom;
            kind     = rnd[1:0];
            accepted = 1'b0;
            tries    = 0;
            while (!accepted && cycles < DS_CYCLES) begin
                @(negedge clk);
                rnd         = $urandom;
                full        = rnd[RS_NUM-1:0];
                uop_valid_i = 1'b1;
                uop_kind_i  = kind;  // a held micro-op keeps its kind.
                rs_full_i   = full;
                #1;
                exp_ready = !full[kind];
                exp_disp  = '0;
                if (exp_ready) begin
                    exp_disp[kind] = 1'b1;
                end
                check_word("uop_ready_o", word_t'(uop_ready_o), word_t'(exp_ready));
                check_word("rs_dispatch_o", word_t'(rs_dispatch_o), word_t'(exp_disp));
                if (exp_ready) begin
                    accepted = 1'b1;
                end else begin
                    exp_blk[kind] = exp_blk[kind] + 1;
                end
                cycles = cycles + 1;
                tries  = tries + 1;
                assert (accepted || tries < HOLD_LIMIT) else begin
                    $display("A micro-op of kind %0d was not accepted within %0d cycles.",
                             kind, HOLD_LIMIT);
                    stop_run();
                end
            end
        end
        @(negedge clk);
        uop_valid_i = 1'b0;
        rs_full_i   = '1; // full stations with no micro-op waiting are no stall.
    endtask

    task automatic read_counter(input perf_sel_t sel, input perf_cnt_t exp, input string name);
        @(negedge clk);
        perf_sel_i = sel;
        @(negedge clk);
        check_word(name, perf_rdata_o, exp);
    endtask

    initial begin
        void'($urandom(32'h214c_5a98));
        rst              = 1'b1;
        br_valid_i       = 1'b0;
        br_opcode_i      = BR_BEQ;
        br_pc_i          = '0;
        br_rs1_i         = '0;
        br_rs2_i         = '0;
        br_imm_i         = '0;
        br_pred_taken_i  = 1'b0;
        br_pred_target_i = '0;
        uop_valid_i      = 1'b0;
        uop_kind_i       = RS_INT;
        rs_full_i        = '0;
        perf_sel_i       = SEL_BR;
        exp_blk          = '{default: '0};
        exp_br           = '0;
        exp_br_miss      = '0;
        exp_cond         = '0;
        exp_cond_miss    = '0;
        exp_uncond       = '0;
        exp_uncond_miss  = '0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_word("redirect_valid_o", word_t'(redirect_valid_o), '0);
        check_word("rs_dispatch_o", word_t'(rs_dispatch_o), '0);
        check_word("perf_rdata_o", perf_rdata_o, '0);

        build_table();
        tally_branches();
        run_branches();
        run_dispatch();

        read_counter(SEL_BR,          exp_br,          "perf_rdata_o[br]");
        read_counter(SEL_BR_MISS,     exp_br_miss,     "perf_rdata_o[br_miss]");
        read_counter(SEL_COND,        exp_cond,        "perf_rdata_o[cond]");
        read_counter(SEL_COND_MISS,   exp_cond_miss,   "perf_rdata_o[cond_miss]");
        read_counter(SEL_UNCOND,      exp_uncond,      "perf_rdata_o[uncond]");
        read_counter(SEL_UNCOND_MISS, exp_uncond_miss, "perf_rdata_o[uncond_miss]");
        read_counter(SEL_INT_BLK,     exp_blk[RS_INT],  "perf_rdata_o[int_blk]");
        read_counter(SEL_INTM_BLK,    exp_blk[RS_INTM], "perf_rdata_o[intm_blk]");
        read_counter(SEL_BR_BLK,      exp_blk[RS_BR],   "perf_rdata_o[br_blk]");
        read_counter(SEL_MEM_BLK,     exp_blk[RS_MEM],  "perf_rdata_o[mem_blk]");
        read_counter(perf_sel_t'(12), '0,               "perf_rdata_o[unused]");

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: flist.f
hw/uop_types.sv
hw/br_resolve_if.sv
hw/ds_perf_if.sv
hw/fu_br.sv
hw/ds_stage.sv
hw/perf_monitor.sv
hw/backend_top.sv
tests/top_tb.sv
